//--- bypass_pipe.f
+incdir+verification
source/isa_pkg.sv
source/pipe_pkg.sv
source/mul_unit.sv
source/reg_file.sv
source/result_stage.sv
source/issue_unit.sv
source/exec_core.sv
verification/exec_core_tb.sv

//--- Bender.yml
package:
  name: bypass_pipe

sources:
  - files:
      - source/isa_pkg.sv
      - source/pipe_pkg.sv
      - source/mul_unit.sv
      - source/reg_file.sv
      - source/result_stage.sv
      - source/issue_unit.sv
      - source/exec_core.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/exec_core_tb.sv

//--- verification/exec_core_checks.svh
// Architectural register state, updated in issue order
word_t ref_regs [32] = '{default: '0};

// Expected result of one operation on two operands
function automatic word_t ref_result(op_type_e op, alu_op_e alu, word_t a, word_t b);
    word_t r;
    if (op == OP_MUL) begin
        r = a * b;
    end else begin
        case (alu)
            ALU_ADD:  r = a + b;
            ALU_SUB:  r = a - b;
            ALU_AND:  r = a & b;
            ALU_OR:   r = a | b;
            ALU_XOR:  r = a ^ b;
            ALU_SLT:  r = ($signed(a) < $signed(b)) ? word_t'(1) : word_t'(0);
            ALU_SLTU: r = (a < b) ? word_t'(1) : word_t'(0);
            ALU_SLL:  r = a << b[5:0];
            ALU_SRL:  r = a >> b[5:0];
            ALU_SRA:  r = word_t'($signed(a) >>> b[5:0]);
            default:  r = '0;
        endcase
    end
    return r;
endfunction

// Reads the model, retires the result into it and returns the commit to expect
task automatic ref_execute(input instr_t instr, output commit_t expected);
    word_t a;
    word_t b;
    a = ref_regs[instr.rs1];
    b = instr.use_imm ? instr.imm : ref_regs[instr.rs2];
    expected.valid = 1'b1;
    expected.rd    = instr.rd;
    expected.data  = ref_result(instr.op_type, instr.alu_op, a, b);
    // x0 stays zero
    if (instr.rd != '0) begin
        ref_regs[instr.rd] = expected.data;
    end
endtask

task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
    if (got !== exp) begin
        stop_run($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
    end
endtask

task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
        stop_run($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
    end
endtask

//--- verification/exec_core_tb.sv
`default_nettype none

module exec_core_tb;
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int NUM_STAGES = 2;
    localparam int CLK_HALF   = 10;
    localparam int N_INDEP    = 40;
    localparam int N_CHAIN    = 30;
    localparam int N_MIX      = 150;
    localparam int NUM_INSTR  = 1 + N_INDEP + (N_CHAIN + 1) + 6 + 4 + N_MIX;
    localparam int TIMEOUT_CYCLES = NUM_INSTR * 40 + 100;

    logic    clk = 1'b0;
    logic    rst_n;
    logic    in_valid;
    instr_t  in_instr;
    logic    in_ready;
    commit_t commit;

    integer  seed = 32'h9b87cb24;
    int      cycle_count = 0;
    commit_t exp_q [$];

    exec_core #(
        .NUM_STAGES (NUM_STAGES)
    ) uut (
        .clk_i      (clk),
        .rst_ni     (rst_n),
        .in_valid_i (in_valid),
        .in_instr_i (in_instr),
        .in_ready_o (in_ready),
        .commit_o   (commit)
    );

    always #CLK_HALF clk = ~clk;

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("** FAIL **");
        $fatal(1);
    endtask

    `include "exec_core_checks.svh"

    function automatic instr_t make_instr(op_type_e op, alu_op_e alu, reg_idx_t rd,
                                          reg_idx_t rs1, reg_idx_t rs2, logic use_imm,
                                          word_t imm);
        instr_t instr;
        instr.op_type = op;
        instr.alu_op  = alu;
        instr.rd      = rd;
        instr.rs1     = rs1;
        instr.rs2     = rs2;
        instr.use_imm = use_imm;
        instr.imm     = imm;
        return instr;
    endfunction

    task automatic random_instr(input bit allow_mul, input int unsigned span,
                                output instr_t instr);
        int unsigned r;
        r = $random(seed);
        instr.op_type = (allow_mul && r[1:0] == 2'b00) ? OP_MUL : OP_ALU;
        instr.alu_op  = alu_op_e'(4'(r[31:8] % 10));
        instr.rd      = reg_idx_t'($unsigned($random(seed)) % span);
        instr.rs1     = reg_idx_t'($unsigned($random(seed)) % span);
        instr.rs2     = reg_idx_t'($unsigned($random(seed)) % span);
        instr.use_imm = r[2];
        // Small immediates give useful shift amounts
        instr.imm     = r[3] ? {$random(seed), $random(seed)}
                             : word_t'($unsigned($random(seed)) % 96);
    endtask

    task automatic record_accept(input instr_t instr);
        commit_t expected;
        ref_execute(instr, expected);
        exp_q.push_back(expected);
    endtask

    // Called on a falling edge, holds the instruction until accepted
    task automatic issue(input instr_t instr);
        in_valid = 1'b1;
        in_instr = instr;
        #(CLK_HALF / 2);
        while (!in_ready) begin
            @(negedge clk);
            #(CLK_HALF / 2);
        end
        record_accept(instr);
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    //////////////////////////////////////////////////
    // Commit comparison
    //////////////////////////////////////////////////

    always @(negedge clk) begin : compare_commits
        commit_t expected;
        if (rst_n && commit.valid) begin
            if (exp_q.size() == 0) begin
                stop_run($sformatf("Commit to x%0d with no accepted instruction waiting",
                                   commit.rd));
            end else begin
                expected = exp_q.pop_front();
                check_reg("commit_o.rd", commit.rd, expected.rd);
                check_word("commit_o.data", commit.data, expected.data);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            stop_run("Timeout with instructions still outstanding");
        end
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    initial begin
        instr_t      instr;
        instr_t      second;
        int unsigned gap;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_instr = '0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        // Quiet after reset, then a first ALU instruction is taken at once
        repeat (4) begin
            @(negedge clk);
            if (commit.valid) stop_run("Commit seen before any instruction was accepted");
        end
        instr = make_instr(OP_ALU, ALU_ADD, 1, 0, 0, 1'b1, 64'h0123_4567_89ab_cdef);
        in_valid = 1'b1;
        in_instr = instr;
        #(CLK_HALF / 2);
        if (!in_ready) stop_run("in_ready_o low for an ALU instruction after reset");
        record_accept(instr);
        @(negedge clk);
        in_valid = 1'b0;
        repeat (NUM_STAGES - 1) begin
            if (commit.valid) stop_run("First ALU result committed too early");
            @(negedge clk);
        end
        if (!commit.valid) stop_run("First ALU result missed its commit cycle");

        // Independent random ALU work
        for (int i = 0; i < N_INDEP; i++) begin
            random_instr(1'b0, 32, instr);
            issue(instr);
        end

        // Back-to-back dependent chain through x5
        issue(make_instr(OP_ALU, ALU_ADD, 5, 0, 0, 1'b1, 64'hfedc_ba98_7654_3210));
        for (int i = 0; i < N_CHAIN; i++) begin
            random_instr(1'b0, 32, instr);
            instr.rd  = 5;
            instr.rs1 = 5;
            if (i % 2 == 1) begin
                instr.rs2     = 5;
                instr.use_imm = 1'b0;
            end
            issue(instr);
        end

        // Multiply with dependents, then a second multiply behind a busy unit
        issue(make_instr(OP_MUL, ALU_ADD, 6, 5, 7, 1'b0, '0));
        issue(make_instr(OP_ALU, ALU_ADD, 8, 6, 5, 1'b0, '0));
        issue(make_instr(OP_ALU, ALU_SUB, 9, 8, 6, 1'b0, '0));
        issue(make_instr(OP_MUL, ALU_ADD, 11, 1, 2, 1'b0, '0));
        second   = make_instr(OP_MUL, ALU_ADD, 12, 3, 4, 1'b0, '0);
        in_valid = 1'b1;
        in_instr = second;
        #(CLK_HALF / 2);
        if (in_ready) stop_run("Second multiply accepted while the first was in flight");
        @(negedge clk);
        issue(second);
        issue(make_instr(OP_ALU, ALU_XOR, 13, 12, 11, 1'b0, '0));

        // Writes to x0 must not stick
        issue(make_instr(OP_ALU, ALU_ADD, 0, 3, 0, 1'b1, 64'h55));
        issue(make_instr(OP_ALU, ALU_ADD, 14, 0, 3, 1'b0, '0));
        issue(make_instr(OP_ALU, ALU_OR, 0, 14, 14, 1'b1, 64'haa));
        issue(make_instr(OP_ALU, ALU_SUB, 15, 3, 0, 1'b0, '0));

        // Long mix over a few registers so hazards are frequent
        for (int i = 0; i < N_MIX; i++) begin
            random_instr(1'b1, 8, instr);
            issue(instr);
            gap = $unsigned($random(seed)) % 5;
            if (gap > 2) repeat (gap - 2) @(negedge clk);
        end

        for (int i = 0; i < 100 && exp_q.size() != 0; i++) @(negedge clk);
        repeat (2 * NUM_STAGES + 4) @(negedge clk);
        if (exp_q.size() != 0) begin
            stop_run($sformatf("%0d accepted instructions never committed", exp_q.size()));
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- source/exec_core.sv
`default_nettype none

module exec_core #(
    parameter int unsigned NUM_STAGES = 2
) (
    input  logic              clk_i,
    input  logic              rst_ni,

    input  logic              in_valid_i,
    input  isa_pkg::instr_t   in_instr_i,
    output logic              in_ready_o,

    output pipe_pkg::commit_t commit_o
);
    import isa_pkg::*;
    import pipe_pkg::*;

    reg_idx_t    rs1_idx;
    reg_idx_t    rs2_idx;
    word_t       rs1_data;
    word_t       rs2_data;

    logic        mul_start;
    logic        mul_ready;
    logic        mul_valid;
    word_t       mul_a;
    word_t       mul_b;
    word_t       mul_data;

    // Link i feeds stage i, the last link is the commit
    logic        link_valid  [NUM_STAGES+1];
    stage_view_t link_entry  [NUM_STAGES+1];
    func_unit_e  link_unit   [NUM_STAGES+1];
    logic        stage_ready [NUM_STAGES+1];
    stage_view_t views       [NUM_STAGES];

    issue_unit #(
        .NUM_STAGES (NUM_STAGES)
    ) u_issue (
        .clk_i,
        .rst_ni,
        .in_valid_i,
        .in_instr_i,
        .in_ready_o,
        .rs1_idx_o      (rs1_idx),
        .rs2_idx_o      (rs2_idx),
        .rs1_data_i     (rs1_data),
        .rs2_data_i     (rs2_data),
        .views_i        (views),
        .stage0_ready_i (stage_ready[0]),
        .issue_o        (link_valid[0]),
        .issue_entry_o  (link_entry[0]),
        .issue_unit_o   (link_unit[0]),
        .mul_ready_i    (mul_ready),
        .mul_start_o    (mul_start),
        .mul_a_o        (mul_a),
        .mul_b_o        (mul_b)
    );

    mul_unit u_mul (
        .clk_i,
        .rst_ni,
        .start_i   (mul_start),
        .a_i       (mul_a),
        .b_i       (mul_b),
        .ready_o   (mul_ready),
        .valid_o   (mul_valid),
        .product_o (mul_data)
    );

    // The tail releases on its own data, so nothing holds it back
    assign stage_ready[NUM_STAGES] = 1'b1;

    for (genvar i = 0; i < NUM_STAGES; i++) begin : g_stage
        result_stage #(
            .IS_TAIL (i == NUM_STAGES - 1)
        ) u_stage (
            .clk_i,
            .rst_ni,
            .in_valid_i   (link_valid[i]),
            .in_entry_i   (link_entry[i]),
            .in_unit_i    (link_unit[i]),
            .ready_o      (stage_ready[i]),
            .next_ready_i (stage_ready[i+1]),
            .mul_valid_i  (mul_valid),
            .mul_data_i   (mul_data),
            .out_valid_o  (link_valid[i+1]),
            .out_entry_o  (link_entry[i+1]),
            .out_unit_o   (link_unit[i+1]),
            .view_o       (views[i])
        );
    end

    assign commit_o = '{
        valid: link_valid[NUM_STAGES],
        rd:    link_entry[NUM_STAGES].rd,
        data:  link_entry[NUM_STAGES].data
    };

    reg_file u_regs (
        .clk_i,
        .rst_ni,
        .rs1_idx_i  (rs1_idx),
        .rs2_idx_i  (rs2_idx),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .commit_i   (commit_o)
    );

endmodule

`default_nettype wire

//--- source/issue_unit.sv
`default_nettype none

module issue_unit #(
    parameter int unsigned NUM_STAGES = 2
) (
    input  logic                  clk_i,
    input  logic                  rst_ni,

    input  logic                  in_valid_i,
    input  isa_pkg::instr_t       in_instr_i,
    output logic                  in_ready_o,

    output isa_pkg::reg_idx_t     rs1_idx_o,
    output isa_pkg::reg_idx_t     rs2_idx_o,
    input  isa_pkg::word_t        rs1_data_i,
    input  isa_pkg::word_t        rs2_data_i,

    input  pipe_pkg::stage_view_t views_i [NUM_STAGES],
    input  logic                  stage0_ready_i,

    output logic                  issue_o,
    output pipe_pkg::stage_view_t issue_entry_o,
    output pipe_pkg::func_unit_e  issue_unit_o,

    input  logic                  mul_ready_i,
    output logic                  mul_start_o,
    output isa_pkg::word_t        mul_a_o,
    output isa_pkg::word_t        mul_b_o
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic                    use_rs1;
    logic                    use_rs2;
    logic                    is_mul;
    logic                    data_hazard;
    logic                    struct_hazard;
    word_t                   rs1_val;
    word_t                   rs2_val;
    word_t                   operand_a;
    word_t                   operand_b;
    logic [XLEN:0]           difference;
    logic                    lt_signed;
    logic                    lt_unsigned;
    logic [$clog2(XLEN)-1:0] shamt;
    word_t                   alu_result;

    // Registers are read straight from the instruction fields
    assign rs1_idx_o = in_instr_i.rs1;
    assign rs2_idx_o = in_instr_i.rs2;

    // x0 never creates a dependency
    assign use_rs1 = in_instr_i.rs1 != '0;
    assign use_rs2 = !in_instr_i.use_imm && in_instr_i.rs2 != '0;
    assign is_mul  = in_instr_i.op_type == OP_MUL;

    //////////////////////////////////////////////////
    // Bypass and hazard detection
    //////////////////////////////////////////////////

    // Walk from the oldest stage to stage 0 so the youngest match wins
    always_comb begin
        rs1_val     = rs1_data_i;
        rs2_val     = rs2_data_i;
        data_hazard = 1'b0;
        for (int i = NUM_STAGES - 1; i >= 0; i--) begin
            if (views_i[i].pending && use_rs1 && views_i[i].rd == in_instr_i.rs1) begin
                if (views_i[i].data_valid) begin
                    rs1_val = views_i[i].data;
                end else begin
                    data_hazard = 1'b1;
                end
            end
            if (views_i[i].pending && use_rs2 && views_i[i].rd == in_instr_i.rs2) begin
                if (views_i[i].data_valid) begin
                    rs2_val = views_i[i].data;
                end else begin
                    data_hazard = 1'b1;
                end
            end
        end
    end

    assign struct_hazard = !stage0_ready_i || (is_mul && !mul_ready_i);

    assign in_ready_o = !data_hazard && !struct_hazard;
    assign issue_o    = in_valid_i && in_ready_o;

    //////////////////////////////////////////////////
    // ALU
    //////////////////////////////////////////////////

    assign operand_a = rs1_val;
    assign operand_b = in_instr_i.use_imm ? in_instr_i.imm : rs2_val;
    assign shamt     = operand_b[$clog2(XLEN)-1:0];

    // Shared by SUB, SLT and SLTU; the top bit is the borrow
    assign difference  = {1'b0, operand_a} - {1'b0, operand_b};
    assign lt_unsigned = difference[XLEN];
    assign lt_signed   = (operand_a[XLEN-1] == operand_b[XLEN-1]) ?
                         difference[XLEN-1] : operand_a[XLEN-1];

    always_comb begin
        unique case (in_instr_i.alu_op)
            ALU_ADD:  alu_result = operand_a + operand_b;
            ALU_SUB:  alu_result = difference[XLEN-1:0];
            ALU_AND:  alu_result = operand_a & operand_b;
            ALU_OR:   alu_result = operand_a | operand_b;
            ALU_XOR:  alu_result = operand_a ^ operand_b;
            ALU_SLT:  alu_result = word_t'(lt_signed);
            ALU_SLTU: alu_result = word_t'(lt_unsigned);
            ALU_SLL:  alu_result = operand_a << shamt;
            ALU_SRL:  alu_result = operand_a >> shamt;
            ALU_SRA:  alu_result = word_t'($signed(operand_a) >>> shamt);
            default:  alu_result = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // Issue into stage 0
    //////////////////////////////////////////////////

    // A multiply enters without data and waits for the late result
    assign issue_entry_o = '{
        pending:    1'b1,
        rd:         in_instr_i.rd,
        data_valid: !is_mul,
        data:       alu_result
    };
    assign issue_unit_o = is_mul ? FU_MUL : FU_ALU;

    assign mul_start_o = issue_o && is_mul;
    assign mul_a_o     = operand_a;
    assign mul_b_o     = operand_b;

    // Start only on an idle multiplier, which then reports busy
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        mul_start_o |-> mul_ready_i ##1 !mul_ready_i);

endmodule

`default_nettype wire

//--- source/result_stage.sv
`default_nettype none

module result_stage #(
    parameter bit IS_TAIL = 1'b0
) (
    input  logic                  clk_i,
    input  logic                  rst_ni,

    input  logic                  in_valid_i,
    input  pipe_pkg::stage_view_t in_entry_i,
    input  pipe_pkg::func_unit_e  in_unit_i,
    output logic                  ready_o,

    input  logic                  next_ready_i,

    input  logic                  mul_valid_i,
    input  isa_pkg::word_t        mul_data_i,

    output logic                  out_valid_o,
    output pipe_pkg::stage_view_t out_entry_o,
    output pipe_pkg::func_unit_e  out_unit_o,

    output pipe_pkg::stage_view_t view_o
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic       pending_q;
    func_unit_e unit_q;
    reg_idx_t   rd_q;
    word_t      data_q;
    logic       data_valid;
    word_t      data;
    logic       mul_capture;
    logic       leave;
    logic       load;

    // A multiply entry sees its result on the pulse itself
    assign mul_capture = unit_q == FU_MUL && mul_valid_i;
    assign data_valid  = unit_q == FU_ALU || mul_valid_i;
    assign data        = (unit_q == FU_MUL) ? mul_data_i : data_q;

    if (IS_TAIL) begin : g_tail
        // Commit as soon as the result is known
        assign out_valid_o = pending_q && data_valid;
        assign ready_o     = !pending_q || data_valid;
        assign leave       = out_valid_o;
    end else begin : g_mid
        assign out_valid_o = pending_q;
        assign ready_o     = !pending_q || next_ready_i;
        assign leave       = pending_q && next_ready_i;
    end

    assign load = in_valid_i && ready_o;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pending_q <= 1'b0;
            unit_q    <= FU_ALU;
        end else begin
            if (mul_capture || leave) begin
                unit_q <= FU_ALU;
            end
            if (leave) begin
                pending_q <= 1'b0;
            end
            if (load) begin
                pending_q <= 1'b1;
                unit_q    <= in_unit_i;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            rd_q   <= in_entry_i.rd;
            data_q <= in_entry_i.data;
        end else if (mul_capture) begin
            data_q <= mul_data_i;
        end
    end

    assign view_o      = '{pending: pending_q, rd: rd_q, data_valid: data_valid, data: data};
    assign out_entry_o = view_o;
    // Data already known travels on as an ALU result
    assign out_unit_o  = data_valid ? FU_ALU : unit_q;

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        mul_capture |-> pending_q);

endmodule

`default_nettype wire

//--- source/reg_file.sv
`default_nettype none

module reg_file (
    input  logic              clk_i,
    input  logic              rst_ni,

    input  isa_pkg::reg_idx_t rs1_idx_i,
    input  isa_pkg::reg_idx_t rs2_idx_i,
    output isa_pkg::word_t    rs1_data_o,
    output isa_pkg::word_t    rs2_data_o,

    input  pipe_pkg::commit_t commit_i
);
    import isa_pkg::*;

    // x0 has no storage
    word_t regs_q [31:1];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (commit_i.valid && commit_i.rd != '0) begin
            regs_q[commit_i.rd] <= commit_i.data;
        end
    end

    //////////////////////////////////////////////////
    // Read ports
    //////////////////////////////////////////////////

    // A write in the same cycle is seen through the tail stage bypass
    assign rs1_data_o = (rs1_idx_i == '0) ? '0 : regs_q[rs1_idx_i];
    assign rs2_data_o = (rs2_idx_i == '0) ? '0 : regs_q[rs2_idx_i];

endmodule

`default_nettype wire

//--- source/mul_unit.sv
`default_nettype none

module mul_unit (
    input  logic           clk_i,
    input  logic           rst_ni,
    input  logic           start_i,
    input  isa_pkg::word_t a_i,
    input  isa_pkg::word_t b_i,
    output logic           ready_o,
    output logic           valid_o,
    output isa_pkg::word_t product_o
);
    import isa_pkg::*;

    // Two multiplier bits retire per cycle
    localparam int unsigned STEPS  = XLEN / 2;
    localparam int unsigned STEP_W = $clog2(STEPS);

    typedef enum logic [1:0] {
        MUL_IDLE,
        MUL_RUN,
        MUL_DONE
    } mul_state_e;

    mul_state_e        state_q;
    logic [STEP_W-1:0] step_q;
    logic              valid_q;
    word_t             a_q;
    word_t             b_q;
    word_t             acc_q;
    word_t             partial;

    // Radix-4 partial product, 0, a, 2a or 3a
    assign partial = (b_q[0] ? a_q : '0) + (b_q[1] ? {a_q[XLEN-2:0], 1'b0} : '0);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= MUL_IDLE;
            step_q  <= '0;
            valid_q <= 1'b0;
        end else begin
            unique case (state_q)
                MUL_IDLE: begin
                    if (start_i) begin
                        state_q <= MUL_RUN;
                        step_q  <= '0;
                    end
                end
                MUL_RUN: begin
                    step_q <= step_q + 1'b1;
                    if (step_q == STEP_W'(STEPS - 1)) begin
                        state_q <= MUL_DONE;
                        valid_q <= 1'b1;
                    end
                end
                MUL_DONE: begin
                    state_q <= MUL_IDLE;
                    valid_q <= 1'b0;
                end
                default: state_q <= MUL_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == MUL_IDLE && start_i) begin
            a_q   <= a_i;
            b_q   <= b_i;
            acc_q <= '0;
        end else if (state_q == MUL_RUN) begin
            acc_q <= acc_q + partial;
            a_q   <= a_q << 2;
            b_q   <= b_q >> 2;
        end
    end

    assign ready_o   = state_q == MUL_IDLE;
    assign valid_o   = valid_q;
    assign product_o = acc_q;

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(valid_o && state_q == MUL_IDLE));

endmodule

`default_nettype wire

//--- source/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    // Where the data of an in-flight entry comes from
    typedef enum logic {
        FU_ALU,
        FU_MUL
    } func_unit_e;

    // What a result stage exposes to the bypass network
    typedef struct packed {
        logic              pending;
        isa_pkg::reg_idx_t rd;
        logic              data_valid;
        isa_pkg::word_t    data;
    } stage_view_t;

    // Retired result, written to the register file
    typedef struct packed {
        logic              valid;
        isa_pkg::reg_idx_t rd;
        isa_pkg::word_t    data;
    } commit_t;

endpackage

`default_nettype wire

//--- source/isa_pkg.sv
`default_nettype none

package isa_pkg;

    // Machine word width
    localparam int unsigned XLEN = 64;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;

    typedef enum logic {
        OP_ALU,
        OP_MUL
    } op_type_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_op_e;

    // Instruction as presented to the issue port
    typedef struct packed {
        op_type_e op_type;
        alu_op_e  alu_op;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        logic     use_imm;
        word_t    imm;
    } instr_t;

endpackage

`default_nettype wire
